//--- design/axi_pkg.sv
// axi_pkg: AXI4-Lite widths, response codes and loader FSM states
package axi_pkg;

  // byte address, offset from the program base
  localparam int axil_addr_w = 16;

  // one data beat carries one instruction word
  localparam int axil_data_w = 32;

  // bresp / rresp encoding, exokay unused on AXI4-Lite
  typedef enum logic [1:0] {
    resp_okay   = 2'b00,
    resp_slverr = 2'b10,
    resp_decerr = 2'b11
  } axi_resp_e;

  // loader FSM
  typedef enum logic [1:0] {
    st_idle,
    st_wr_resp,
    st_rd_wait,
    st_rd_resp
  } loader_state_e;

endpackage

//--- design/axil_loader.sv
// axil_loader: AXI4-Lite slave that loads and reads back the program as masked row accesses
`timescale 1ns/10ps

module axil_loader import axi_pkg::*; #(
  parameter int mem_rows = 64,
  localparam int idx_w = $clog2(mem_rows)
) (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       run,
  input  logic [axil_addr_w-1:0]     awaddr,
  input  logic                       awvalid,
  output logic                       awready,
  input  logic [axil_data_w-1:0]     wdata,
  input  logic [axil_data_w/8-1:0]   wstrb,
  input  logic                       wvalid,
  output logic                       wready,
  output axi_resp_e                  bresp,
  output logic                       bvalid,
  input  logic                       bready,
  input  logic [axil_addr_w-1:0]     araddr,
  input  logic                       arvalid,
  output logic                       arready,
  output logic [axil_data_w-1:0]     rdata,
  output axi_resp_e                  rresp,
  output logic                       rvalid,
  input  logic                       rready,
  mem_wr_if.src                      wr,
  output logic [idx_w-1:0]           rd_idx,
  input  logic [2*axil_data_w-1:0]   rd_row
);

  // first byte offset past the memory
  localparam logic [axil_addr_w:0] addr_lim = (axil_addr_w + 1)'(mem_rows * 8);

  loader_state_e            state;
  logic                     wr_go;
  logic                     rd_go;
  logic                     aw_in_range;
  logic                     ar_in_range;
  axi_resp_e                wr_resp;
  axi_resp_e                rd_resp;
  logic [axil_data_w-1:0]   strb_bits;
  logic                     rd_half;
  logic [axil_data_w-1:0]   rd_word;

  // aw and w taken together, only when both are offered
  assign wr_go   = (state == st_idle) && awvalid && wvalid;
  assign awready = wr_go;
  assign wready  = wr_go;

  // a write in the same cycle wins over a read
  assign rd_go   = (state == st_idle) && arvalid && !wr_go;
  assign arready = rd_go;

  // range check on the byte offset
  assign aw_in_range = {1'b0, awaddr} < addr_lim;
  assign ar_in_range = {1'b0, araddr} < addr_lim;

  // out of range first, then the run lock
  always_comb begin
    if (!aw_in_range) begin
      wr_resp = resp_decerr;
    end else if (run) begin
      wr_resp = resp_slverr;
    end else begin
      wr_resp = resp_okay;
    end
  end

  always_comb begin
    if (!ar_in_range) begin
      rd_resp = resp_decerr;
    end else if (run) begin
      rd_resp = resp_slverr;
    end else begin
      rd_resp = resp_okay;
    end
  end

  // each strobe byte covers 8 mask bits
  always_comb begin
    for (int i = 0; i < axil_data_w / 8; i++) begin
      strb_bits[8*i +: 8] = {8{wstrb[i]}};
    end
  end

  // row write, same edge as the aw/w handshake
  // addr bit 2 picks the upper or lower word
  assign wr.wen   = wr_go && (wr_resp == resp_okay);
  assign wr.widx  = awaddr[idx_w+2:3];
  assign wr.wdata = awaddr[2] ? {wdata, {axil_data_w{1'b0}}} : {{axil_data_w{1'b0}}, wdata};
  assign wr.wmask = awaddr[2] ? {strb_bits, {axil_data_w{1'b0}}}
                              : {{axil_data_w{1'b0}}, strb_bits};

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= st_idle;
    end else begin
      case (state)
        st_idle: begin
          if (wr_go) begin
            state <= st_wr_resp;
          end else if (rd_go) begin
            state <= st_rd_wait;
          end
        end
        st_wr_resp: begin
          if (bready) begin
            state <= st_idle;
          end
        end
        // memory row lands at the end of this cycle
        st_rd_wait: state <= st_rd_resp;
        st_rd_resp: begin
          if (rready) begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // response payloads, captured at the accepting beat
  always_ff @(posedge clk) begin
    if (wr_go) begin
      bresp <= wr_resp;
    end
    if (rd_go) begin
      rresp   <= rd_resp;
      rd_half <= araddr[2];
      rd_idx  <= araddr[idx_w+2:3];
    end
  end

  assign bvalid = (state == st_wr_resp);
  assign rvalid = (state == st_rd_resp);

  // word select from the registered row, zero on an error response
  assign rd_word = rd_half ? rd_row[2*axil_data_w-1:axil_data_w] : rd_row[axil_data_w-1:0];
  assign rdata   = (rresp == resp_okay) ? rd_word : '0;

endmodule

//--- design/cycle_sequencer.sv
// cycle_sequencer: counts cycles within each instruction and flags the last one
`timescale 1ns/10ps

module cycle_sequencer #(
  parameter int cycles_per_inst = 3
) (
  input  logic clk,
  input  logic rst,
  input  logic run,
  output logic last_cycle
);

  localparam int cnt_w = $clog2(cycles_per_inst);
  localparam logic [cnt_w-1:0] cnt_top = cnt_w'(cycles_per_inst - 1);

  logic [cnt_w-1:0] cnt;

  // stopped core parks at count 0
  always_ff @(posedge clk) begin
    if (rst || !run) begin
      cnt <= '0;
    end else if (cnt == cnt_top) begin
      cnt <= '0;
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

  // no retire on the cycle run drops
  assign last_cycle = run && (cnt == cnt_top);

endmodule

//--- design/fetch_top.sv
// fetch_top: AXI4-Lite program loader, program memory, cycle sequencer and fetch stage
`timescale 1ns/10ps

module fetch_top import rv_pkg::*, axi_pkg::*; #(
  parameter int mem_rows        = 64,
  parameter int cycles_per_inst = 3
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     run,
  input  logic [axil_addr_w-1:0]   awaddr,
  input  logic                     awvalid,
  output logic                     awready,
  input  logic [axil_data_w-1:0]   wdata,
  input  logic [axil_data_w/8-1:0] wstrb,
  input  logic                     wvalid,
  output logic                     wready,
  output logic [1:0]               bresp,
  output logic                     bvalid,
  input  logic                     bready,
  input  logic [axil_addr_w-1:0]   araddr,
  input  logic                     arvalid,
  output logic                     arready,
  output logic [axil_data_w-1:0]   rdata,
  output logic [1:0]               rresp,
  output logic                     rvalid,
  input  logic                     rready,
  output logic                     retire_valid,
  output logic [xlen-1:0]          retire_pc,
  output logic [inst_w-1:0]        retire_inst
);

  localparam int idx_w = $clog2(mem_rows);

  // loader readback path
  logic [idx_w-1:0] rd_idx;
  logic [row_w-1:0] rd_row;
  // fetch path
  logic [idx_w-1:0] fetch_idx;
  logic [row_w-1:0] fetch_row;
  logic             last_cycle;

  mem_wr_if #(.mem_rows(mem_rows)) wr_bus ();

  axil_loader #(.mem_rows(mem_rows)) u_loader (
    .clk(clk), .rst(rst), .run(run),
    .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
    .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
    .bresp(bresp), .bvalid(bvalid), .bready(bready),
    .araddr(araddr), .arvalid(arvalid), .arready(arready),
    .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
    .wr(wr_bus.src), .rd_idx(rd_idx), .rd_row(rd_row)
  );

  prog_mem #(.mem_rows(mem_rows)) u_mem (
    .clk(clk), .wr(wr_bus.dst),
    .rd_idx(rd_idx), .rd_row(rd_row),
    .fetch_idx(fetch_idx), .fetch_row(fetch_row)
  );

  cycle_sequencer #(.cycles_per_inst(cycles_per_inst)) u_seq (
    .clk(clk), .rst(rst), .run(run), .last_cycle(last_cycle)
  );

  if_stage #(.mem_rows(mem_rows)) u_if (
    .clk(clk), .rst(rst), .last_cycle(last_cycle),
    .fetch_idx(fetch_idx), .fetch_row(fetch_row),
    .retire_valid(retire_valid), .retire_pc(retire_pc), .retire_inst(retire_inst)
  );

endmodule

//--- design/if_stage.sv
// if_stage: pc register, half-row instruction select, JAL predecode and retire stream
`timescale 1ns/10ps

module if_stage import rv_pkg::*; #(
  parameter int mem_rows = 64,
  localparam int idx_w = $clog2(mem_rows)
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              last_cycle,
  output logic [idx_w-1:0]  fetch_idx,
  input  logic [row_w-1:0]  fetch_row,
  output logic              retire_valid,
  output logic [xlen-1:0]   retire_pc,
  output logic [inst_w-1:0] retire_inst
);

  logic [xlen-1:0]   pc;
  logic [xlen-1:0]   pc_off;
  logic [xlen-1:0]   next_pc;
  logic [xlen-1:0]   jal_imm;
  logic [inst_w-1:0] inst;
  opcode_e           opc;

  // row index relative to the memory base, 8 bytes per row
  assign pc_off    = pc - pc_start;
  assign fetch_idx = pc_off[idx_w+2:3];

  // pc[2] set means the odd word, upper half of the row
  assign inst = pc[2] ? fetch_row[row_w-1:inst_w] : fetch_row[inst_w-1:0];

  // predecode of the major opcode
  always_comb begin
    case (inst[6:0])
      op_jal:    opc = op_jal;
      op_jalr:   opc = op_jalr;
      op_branch: opc = op_branch;
      op_op_imm: opc = op_op_imm;
      default:   opc = op_other;
    endcase
  end

  // J-type immediate, imm[20|10:1|11|19:12] in inst[31:12]
  assign jal_imm = {{(xlen-21){inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  // jalr and branches need registers, they fall through here
  assign next_pc = (opc == op_jal) ? pc + jal_imm : pc + 64'd4;

  // pc moves only at the end of an instruction
  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= pc_start;
    end else if (last_cycle) begin
      pc <= next_pc;
    end
  end

  // retire shows the instruction that ends this cycle
  assign retire_valid = last_cycle;
  assign retire_pc    = pc;
  assign retire_inst  = inst;

endmodule

//--- design/mem_wr_if.sv
// mem_wr_if: masked row write port from the program loader into program memory
`timescale 1ns/10ps

interface mem_wr_if import rv_pkg::*; #(
  parameter int mem_rows = 64
) ();

  localparam int idx_w = $clog2(mem_rows);

  // write strobe, one row per cycle
  logic             wen;
  logic [idx_w-1:0] widx;
  logic [row_w-1:0] wdata;
  // bit-granular mask, bytes expanded from wstrb
  logic [row_w-1:0] wmask;

  // loader side
  modport src (output wen, output widx, output wdata, output wmask);

  // memory side
  modport dst (input wen, input widx, input wdata, input wmask);

endinterface

//--- design/prog_mem.sv
// prog_mem: 64-bit row program memory with masked write, async fetch read and registered readback
`timescale 1ns/10ps

module prog_mem import rv_pkg::*; #(
  parameter int mem_rows = 64,
  localparam int idx_w = $clog2(mem_rows)
) (
  input  logic             clk,
  mem_wr_if.dst            wr,
  input  logic [idx_w-1:0] rd_idx,
  output logic [row_w-1:0] rd_row,
  input  logic [idx_w-1:0] fetch_idx,
  output logic [row_w-1:0] fetch_row
);

  // two instructions per row, low word at the lower address
  logic [row_w-1:0] mem [mem_rows];

  // masked write, untouched bits keep their old value
  always_ff @(posedge clk) begin
    if (wr.wen) begin
      mem[wr.widx] <= (mem[wr.widx] & ~wr.wmask) | (wr.wdata & wr.wmask);
    end
  end

  // loader readback
  // one cycle of latency, index held by the loader while it waits
  always_ff @(posedge clk) begin
    rd_row <= mem[rd_idx];
  end

  // fetch sees the row in the same cycle as its index
  assign fetch_row = mem[fetch_idx];

endmodule

//--- design/rv_pkg.sv
// rv_pkg: core constants, widths and major opcode encoding for the fetch path
package rv_pkg;

  // integer register and pc width
  localparam int xlen = 64;

  // one instruction word
  localparam int inst_w = 32;

  // program memory row, two instructions side by side
  localparam int row_w = 64;

  // first pc after reset, also the base of the program memory
  localparam logic [xlen-1:0] pc_start = 64'h8000_0000;

  // major opcode field, inst[6:0]
  // only jal changes the fetch flow here, the rest go sequential
  typedef enum logic [6:0] {
    op_jal    = 7'b1101111,
    op_jalr   = 7'b1100111,
    op_branch = 7'b1100011,
    op_op_imm = 7'b0010011,
    op_other  = 7'b0000000
  } opcode_e;

endpackage

//--- filelist.f
design/rv_pkg.sv
design/axi_pkg.sv
design/mem_wr_if.sv
design/prog_mem.sv
design/axil_loader.sv
design/cycle_sequencer.sv
design/if_stage.sv
design/fetch_top.sv
sim/tb_fetch.sv

//--- run_sim.sh
#!/bin/sh
# build the fetch testbench with Verilator, run it, judge the run from its log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module tb_fetch -f filelist.f -o tb_fetch \
  || { echo "build failed"; exit 1; }
./obj_dir/tb_fetch > sim.log 2>&1 || echo "simulator returned an error status"
cat sim.log
grep -q "Simulation failed" sim.log && { echo "FAIL"; exit 1; }
grep -q "Simulation passed" sim.log || { echo "FAIL: no result in log"; exit 1; }
echo "PASS"

//--- sim/tb_fetch.sv
// tb_fetch: random program load, readback and run of the fetch path against a fetch model
`timescale 1ns/10ps

module tb_fetch import rv_pkg::*, axi_pkg::*; ();

  localparam int mem_rows        = 64;
  localparam int cycles_per_inst = 3;
  localparam int n_words         = mem_rows * 2;
  localparam int n_run           = 400;
  // full load, full readback, decerr pair, partial write, refused write
  localparam int n_xact          = 2 * n_words + 4;
  localparam int cycle_limit     = n_xact * 10 + n_run * cycles_per_inst + 200;

  logic clk;
  logic rst;
  logic run;
  logic [axil_addr_w-1:0]   awaddr;
  logic                     awvalid;
  logic                     awready;
  logic [axil_data_w-1:0]   wdata;
  logic [axil_data_w/8-1:0] wstrb;
  logic                     wvalid;
  logic                     wready;
  logic [1:0]               bresp;
  logic                     bvalid;
  logic                     bready;
  logic [axil_addr_w-1:0]   araddr;
  logic                     arvalid;
  logic                     arready;
  logic [axil_data_w-1:0]   rdata;
  logic [1:0]               rresp;
  logic                     rvalid;
  logic                     rready;
  logic                     retire_valid;
  logic [xlen-1:0]          retire_pc;
  logic [inst_w-1:0]        retire_inst;

  // fetch model state
  logic [inst_w-1:0] prog [n_words];
  logic [xlen-1:0]   m_pc;
  logic [31:0]       rng;
  int                cycles = 0;
  int                last_ret;
  int                n_retired;
  logic              running;

  fetch_top #(.mem_rows(mem_rows), .cycles_per_inst(cycles_per_inst)) uut (
    .clk(clk), .rst(rst), .run(run),
    .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
    .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
    .bresp(bresp), .bvalid(bvalid), .bready(bready),
    .araddr(araddr), .arvalid(arvalid), .arready(arready),
    .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
    .retire_valid(retire_valid), .retire_pc(retire_pc), .retire_inst(retire_inst)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1);
  endtask

  // cycle count, also the hang guard
  always @(posedge clk) begin
    cycles++;
    if (cycles >= cycle_limit) begin
      report_failure("timeout: the run went past its cycle limit");
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] rand32();
    rng = xorshift32(rng);
    return rng;
  endfunction

  // J-type layout, imm[20|10:1|11|19:12] then rd then opcode
  function automatic logic [inst_w-1:0] make_jal(input int from_idx, input int to_idx,
                                                 input logic [4:0] rd);
    logic [20:0] off;
    off = 21'((to_idx - from_idx) * 4);
    return {off[20], off[10:1], off[11], off[19:12], rd, op_jal};
  endfunction

  function automatic logic [inst_w-1:0] model_inst(input logic [xlen-1:0] pc);
    logic [xlen-1:0] off;
    off = (pc - pc_start) >> 2;
    return prog[off[$clog2(n_words)-1:0]];
  endfunction

  // jal jumps by its sign-extended offset, all else steps one word
  function automatic logic [xlen-1:0] model_next_pc(input logic [xlen-1:0] pc,
                                                    input logic [inst_w-1:0] inst);
    longint off;
    if (inst[6:0] != op_jal) begin
      return pc + 64'd4;
    end
    // offset summed field by field, bit 31 weighs -2^20
    off = longint'(inst[30:21]) * 2 + longint'(inst[20]) * 2048
        + longint'(inst[19:12]) * 4096;
    if (inst[31]) off = off - 1048576;
    return pc + 64'(off);
  endfunction

  // forward jumps only, last word closes the loop
  task automatic build_program();
    logic [31:0] r;
    int t;
    for (int i = 0; i < n_words; i++) begin
      r = rand32();
      if (i == n_words - 1) begin
        prog[i] = make_jal(i, 0, r[11:7]);
      end else if (rand32() % 8 == 0) begin
        t = i + 1 + int'(rand32() % (n_words - 1 - i));
        prog[i] = make_jal(i, t, r[11:7]);
      end else begin
        prog[i] = r;
        if (r[6:0] == op_jal) prog[i][6:0] = op_op_imm;
      end
    end
  endtask

  // nothing pending and nothing offered right after reset
  task automatic verify_reset_state();
    if (retire_valid !== 1'b0 || bvalid !== 1'b0 || rvalid !== 1'b0 ||
        awready !== 1'b0 || wready !== 1'b0 || arready !== 1'b0) begin
      report_failure("a valid or ready output was high right after reset");
    end
  endtask

  task automatic check_resp(input axi_resp_e got, input axi_resp_e want, input string what);
    if (got !== want) begin
      report_failure($sformatf("** Error at %0t: %s response %b, expected %b",
                               $time, what, got, want));
    end
  endtask

  task automatic check_word(input logic [axil_data_w-1:0] got,
                            input logic [axil_data_w-1:0] want, input string what);
    if (got !== want) begin
      report_failure($sformatf("** Error at %0t: %s %h, expected %h", $time, what, got, want));
    end
  endtask

  task automatic check_retire(input logic [xlen-1:0] got_pc, input logic [inst_w-1:0] got_inst,
                              input logic [xlen-1:0] want_pc, input logic [inst_w-1:0] want_inst);
    if (got_pc !== want_pc || got_inst !== want_inst) begin
      report_failure($sformatf("** Error at %0t: retire pc %h inst %h, expected pc %h inst %h",
                               $time, got_pc, got_inst, want_pc, want_inst));
    end
  endtask

  // aw and w offered together, bready raised right after the beat
  task automatic axi_write(input logic [axil_addr_w-1:0] addr, input logic [31:0] data,
                           input logic [3:0] strb, input axi_resp_e want);
    @(negedge clk);
    awaddr  = addr;
    wdata   = data;
    wstrb   = strb;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    #1;
    while (!(awready && wready)) begin
      @(negedge clk);
      #1;
    end
    // beat on the next rising edge
    @(negedge clk);
    awvalid = 1'b0;
    wvalid  = 1'b0;
    bready  = 1'b1;
    #1;
    if (!bvalid) report_failure("bvalid did not come one cycle after the write beat");
    check_resp(axi_resp_e'(bresp), want, "write");
    @(negedge clk);
    bready = 1'b0;
  endtask

  // rvalid two cycles after the ar beat, then a random rready delay
  task automatic axi_read(input logic [axil_addr_w-1:0] addr, input logic [31:0] want_data,
                          input axi_resp_e want);
    int delay;
    delay = int'(rand32() % 4);
    @(negedge clk);
    araddr  = addr;
    arvalid = 1'b1;
    #1;
    while (!arready) begin
      @(negedge clk);
      #1;
    end
    @(negedge clk);
    arvalid = 1'b0;
    #1;
    if (rvalid) report_failure("rvalid came one cycle after the read beat instead of two");
    @(negedge clk);
    #1;
    if (!rvalid) report_failure("rvalid missing two cycles after the read beat");
    repeat (delay) begin
      @(negedge clk);
      #1;
      if (!rvalid) report_failure("rvalid dropped before rready");
    end
    @(negedge clk);
    rready = 1'b1;
    #1;
    check_resp(axi_resp_e'(rresp), want, "read");
    if (want == resp_okay) check_word(rdata, want_data, "read data");
    @(negedge clk);
    rready = 1'b0;
  endtask

  // retire monitor, mid-cycle after the falling edge drive
  always @(negedge clk) begin
    #1;
    if (running) begin
      if (retire_valid !== (cycles - last_ret == cycles_per_inst)) begin
        report_failure($sformatf("** Error at %0t: retire_valid %b at cycle %0d, last at %0d",
                                 $time, retire_valid, cycles, last_ret));
      end
      if (retire_valid) begin
        check_retire(retire_pc, retire_inst, m_pc, model_inst(m_pc));
        m_pc = model_next_pc(m_pc, model_inst(m_pc));
        last_ret = cycles;
        n_retired++;
      end
    end
  end

  initial begin
    logic [axil_addr_w-1:0] bad;
    logic [31:0]            r;
    logic [3:0]             strb;
    int                     pidx;
    rng       = 32'h73ae4b08;
    running   = 1'b0;
    n_retired = 0;
    last_ret  = 0;
    m_pc      = pc_start;
    rst       = 1'b1;
    run       = 1'b0;
    awaddr    = '0;
    awvalid   = 1'b0;
    wdata     = '0;
    wstrb     = '0;
    wvalid    = 1'b0;
    bready    = 1'b0;
    araddr    = '0;
    arvalid   = 1'b0;
    rready    = 1'b0;
    build_program();
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    #1;
    verify_reset_state();

    // full program load
    for (int i = 0; i < n_words; i++) begin
      axi_write(16'(i * 4), prog[i], 4'hf, resp_okay);
    end

    // past the end of memory, both directions
    bad = 16'(mem_rows * 8 + int'(rand32() % (65536 - mem_rows * 8)));
    bad[1:0] = 2'b00;
    axi_write(bad, rand32(), 4'hf, resp_decerr);
    axi_read(bad, 32'h0, resp_decerr);

    // partial strobe on a non-jal word, byte 0 kept so the opcode stays
    pidx = int'(rand32() % (n_words - 1));
    while (prog[pidx][6:0] == op_jal) pidx = (pidx + 1) % (n_words - 1);
    r = rand32();
    strb = {r[31:29], 1'b0};
    if (strb == 4'b0000) strb = 4'b0100;
    axi_write(16'(pidx * 4), r, strb, resp_okay);
    for (int b = 1; b < 4; b++) begin
      if (strb[b]) prog[pidx][8*b +: 8] = r[8*b +: 8];
    end

    // full readback, partial word and decerr alias included
    for (int i = 0; i < n_words; i++) begin
      axi_read(16'(i * 4), prog[i], resp_okay);
    end

    // run, the cycle run rises in already counts as count 0
    @(negedge clk);
    run = 1'b1;
    running = 1'b1;
    last_ret = cycles - 1;
    wait (n_retired >= n_run / 2);

    // write while running is refused, word 0 runs again after the next wrap
    axi_write(16'h0000, ~prog[0], 4'hf, resp_slverr);
    wait (n_retired >= n_run);

    $display("Simulation passed");
    $finish;
  end

endmodule
